//--- rtl/wiscCore_settings.svh
// wisc execute core sizing
// data word width, register count and data memory depth shared by
// the package and every block of the core

`ifndef WISC_CORE_SETTINGS_SVH
`define WISC_CORE_SETTINGS_SVH

// width of one data word and of the pc
`define WISC_DATA_WIDTH 16
// eight architectural registers, 3-bit index
`define WISC_REG_COUNT 8
// data memory depth in words
`define WISC_DMEM_WORDS 64

`endif

//--- rtl/wiscPkg.sv
// wisc core types
// opcode and function encodings, the instruction word views, the
// decoded control bundle and the retire record

`include "wiscCore_settings.svh"

package wiscPkg;

	//////////////////////////////////////////////////////////////////////
	// encodings
	typedef enum logic [4:0] {
		OP_HALT = 5'b00000, OP_NOP  = 5'b00001, OP_SIIC = 5'b00010, OP_RTI  = 5'b00011,
		OP_J    = 5'b00100, OP_JR   = 5'b00101, OP_JAL  = 5'b00110, OP_JALR = 5'b00111,
		OP_SUBI = 5'b01000, OP_ADDI = 5'b01001, OP_ANDNI = 5'b01010, OP_XORI = 5'b01011,
		OP_BNEZ = 5'b01100, OP_BEQZ = 5'b01101, OP_BLTZ = 5'b01110, OP_BGEZ = 5'b01111,
		OP_ST   = 5'b10000, OP_LD   = 5'b10001, OP_SLBI = 5'b10010, OP_STU  = 5'b10011,
		OP_ROLI = 5'b10100, OP_SLLI = 5'b10101, OP_RORI = 5'b10110, OP_SRLI = 5'b10111,
		OP_LBI  = 5'b11000, OP_BTR  = 5'b11001, OP_ALU2 = 5'b11010, OP_ALU1 = 5'b11011,
		OP_SEQ  = 5'b11100, OP_SLT  = 5'b11101, OP_SLE  = 5'b11110, OP_SCO  = 5'b11111
	} opcodeT;

	// funct field, meaning depends on the R-format group
	typedef logic [1:0] functT;
	localparam functT FN_ADD = 2'b00, FN_SUB = 2'b01, FN_XOR = 2'b10, FN_ANDN = 2'b11;
	localparam functT FN_ROL = 2'b00, FN_SLL = 2'b01, FN_ROR = 2'b10, FN_SRL = 2'b11;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_XOR, ALU_ANDN, ALU_ROL, ALU_SLL, ALU_ROR, ALU_SRL,
		ALU_SEQ, ALU_SLT, ALU_SLE, ALU_BTR, ALU_LBI, ALU_SLBI
	} aluOpT;

	// immediate extension selector
	typedef enum logic [2:0] {
		SE_ZEXT5 = 3'b000, SE_ZEXT8 = 3'b001, SE_SEXT5 = 3'b010,
		SE_SEXT8 = 3'b100, SE_SEXT11 = 3'b110
	} seSelT;

	// destination: rd at 4:2, rd at 7:5, rs, or r7 for links
	typedef enum logic [1:0] {RD_RFMT, RD_IFMT, RD_RS, RD_R7} regDstT;

	//////////////////////////////////////////////////////////////////////
	// instruction word, one 16-bit word seen four ways
	typedef struct packed {
		opcodeT opcode;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] rd;
		functT funct;
	} rFmtT;

	typedef struct packed {
		opcodeT opcode;
		logic [2:0] rs;
		logic [2:0] rd;
		logic [4:0] imm5;
	} iFmt1T;

	typedef struct packed {
		opcodeT opcode;
		logic [2:0] rs;
		logic [7:0] imm8;
	} iFmt2T;

	typedef struct packed {
		opcodeT opcode;
		logic [10:0] disp;
	} jFmtT;

	typedef union packed {
		rFmtT rFmt;
		iFmt1T iFmt1;
		iFmt2T iFmt2;
		jFmtT jFmt;
	} instrT;

	//////////////////////////////////////////////////////////////////////
	// decoder output
	typedef struct packed {
		logic regWrite;
		regDstT regDst;
		seSelT seSel;
		logic aluSrc2;
		logic invA;
		logic invB;
		logic cin;
		aluOpT aluOp;
		logic memEn;
		logic memWrite;
		logic memToReg;
		logic branching;
		logic jump;
		logic pcImm;
		logic halt;
		logic err;
	} ctrlT;

	// one retired instruction
	typedef struct packed {
		logic regWrite;
		logic [$clog2(`WISC_REG_COUNT)-1:0] wrReg;
		logic [`WISC_DATA_WIDTH-1:0] wrData;
		logic [`WISC_DATA_WIDTH-1:0] nextPc;
		logic memWrite;
		logic [`WISC_DATA_WIDTH-1:0] memAddr;
		logic [`WISC_DATA_WIDTH-1:0] memData;
		logic halt;
		logic err;
	} retireT;

endpackage

//--- rtl/control.sv
// wisc instruction decoder
// maps the 5-bit opcode and 2-bit funct field onto the control bundle
// used by the register file, alu, branch unit and data memory

`timescale 1ns/1ps

module control (
	input  wiscPkg::opcodeT opcode,
	input  wiscPkg::functT  funct,
	output wiscPkg::ctrlT   ctrl
);

	import wiscPkg::*;

	always_comb begin
		// defaults: write a register, second operand from rt
		ctrl = '0;
		ctrl.regWrite = 1'b1;
		ctrl.aluSrc2 = 1'b1;
		ctrl.regDst = RD_RFMT;
		ctrl.seSel = SE_ZEXT5;
		ctrl.aluOp = ALU_ADD;

		case (opcode)
			//////////////////////////////////////////////////////////////////////
			// R-format
			OP_ALU1: begin
				case (funct)
					FN_ADD: ctrl.aluOp = ALU_ADD;
					// rt - rs as ~rs + rt + 1
					FN_SUB: begin
						ctrl.invA = 1'b1;
						ctrl.cin = 1'b1;
					end
					FN_XOR: ctrl.aluOp = ALU_XOR;
					FN_ANDN: begin
						ctrl.invB = 1'b1;
						ctrl.aluOp = ALU_ANDN;
					end
				endcase
			end
			OP_ALU2: begin
				case (funct)
					FN_ROL: ctrl.aluOp = ALU_ROL;
					FN_SLL: ctrl.aluOp = ALU_SLL;
					FN_ROR: ctrl.aluOp = ALU_ROR;
					FN_SRL: ctrl.aluOp = ALU_SRL;
				endcase
			end
			// set ops subtract rt from rs, the alu looks at the difference
			OP_SEQ, OP_SLT, OP_SLE: begin
				ctrl.invB = 1'b1;
				ctrl.cin = 1'b1;
				ctrl.aluOp = (opcode == OP_SEQ) ? ALU_SEQ :
					(opcode == OP_SLT) ? ALU_SLT : ALU_SLE;
			end
			OP_BTR: ctrl.aluOp = ALU_BTR;

			//////////////////////////////////////////////////////////////////////
			// I-format 1, destination in bits 7:5
			OP_SUBI, OP_ADDI: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.seSel = SE_SEXT5;
				ctrl.regDst = RD_IFMT;
				// imm - rs
				ctrl.invA = (opcode == OP_SUBI);
				ctrl.cin = (opcode == OP_SUBI);
			end
			OP_ANDNI, OP_XORI: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.regDst = RD_IFMT;
				ctrl.invB = (opcode == OP_ANDNI);
				ctrl.aluOp = (opcode == OP_ANDNI) ? ALU_ANDN : ALU_XOR;
			end
			// shift amount is the zero-extended imm
			OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.regDst = RD_IFMT;
				case (opcode)
					OP_ROLI: ctrl.aluOp = ALU_ROL;
					OP_SLLI: ctrl.aluOp = ALU_SLL;
					OP_RORI: ctrl.aluOp = ALU_ROR;
					default: ctrl.aluOp = ALU_SRL;
				endcase
			end
			// address = rs + sext(imm5), store data comes from bits 7:5
			OP_ST, OP_STU: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.seSel = SE_SEXT5;
				ctrl.memEn = 1'b1;
				ctrl.memWrite = 1'b1;
				// stu writes the address back into rs
				ctrl.regWrite = (opcode == OP_STU);
				ctrl.regDst = RD_RS;
			end
			OP_LD: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.seSel = SE_SEXT5;
				ctrl.memEn = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regDst = RD_IFMT;
			end

			//////////////////////////////////////////////////////////////////////
			// I-format 2
			OP_BNEZ, OP_BEQZ, OP_BLTZ, OP_BGEZ: begin
				ctrl.seSel = SE_SEXT8;
				ctrl.regWrite = 1'b0;
				ctrl.branching = 1'b1;
			end
			OP_LBI: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.seSel = SE_SEXT8;
				ctrl.regDst = RD_RS;
				ctrl.aluOp = ALU_LBI;
			end
			OP_SLBI: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.seSel = SE_ZEXT8;
				ctrl.regDst = RD_RS;
				ctrl.aluOp = ALU_SLBI;
			end
			// register-relative jumps, jalr links through r7
			OP_JR, OP_JALR: begin
				ctrl.seSel = SE_SEXT8;
				ctrl.jump = 1'b1;
				ctrl.regWrite = (opcode == OP_JALR);
				ctrl.regDst = RD_R7;
			end

			//////////////////////////////////////////////////////////////////////
			// J-format, pc-relative
			OP_J, OP_JAL: begin
				ctrl.seSel = SE_SEXT11;
				ctrl.pcImm = 1'b1;
				ctrl.regWrite = (opcode == OP_JAL);
				ctrl.regDst = RD_R7;
			end

			OP_NOP: ctrl.regWrite = 1'b0;
			OP_HALT: begin
				ctrl.regWrite = 1'b0;
				ctrl.halt = 1'b1;
			end
			// siic, rti, sco and anything else are not supported here
			default: begin
				ctrl.regWrite = 1'b0;
				ctrl.err = 1'b1;
			end
		endcase
	end

endmodule

//--- rtl/regFile.sv
// wisc register file
// eight data registers, two combinational read ports and one write
// port that lands on the rising clock edge

`timescale 1ns/1ps

`include "wiscCore_settings.svh"

module regFile (
	input  logic clk,
	input  logic reset,
	input  logic [$clog2(`WISC_REG_COUNT)-1:0] rdAddrA,
	input  logic [$clog2(`WISC_REG_COUNT)-1:0] rdAddrB,
	input  logic wrEn,
	input  logic [$clog2(`WISC_REG_COUNT)-1:0] wrAddr,
	input  logic [`WISC_DATA_WIDTH-1:0] wrData,
	output logic [`WISC_DATA_WIDTH-1:0] rdDataA,
	output logic [`WISC_DATA_WIDTH-1:0] rdDataB
);

	logic [`WISC_DATA_WIDTH-1:0] regs [`WISC_REG_COUNT];

	// all registers start at zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `WISC_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// no bypass, a write shows up for the next instruction
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

//--- rtl/alu.sv
// wisc alu
// one adder shared by add, subtract and the set compares, plus logic,
// shift, rotate, bit reverse and the two byte-immediate loads

`timescale 1ns/1ps

`include "wiscCore_settings.svh"

module alu (
	input  logic [`WISC_DATA_WIDTH-1:0] opA,
	input  logic [`WISC_DATA_WIDTH-1:0] opB,
	input  wiscPkg::aluOpT aluOp,
	input  logic invA,
	input  logic invB,
	input  logic cin,
	output logic [`WISC_DATA_WIDTH-1:0] result
);

	import wiscPkg::*;

	localparam int W = `WISC_DATA_WIDTH;
	localparam int SHW = $clog2(W);

	logic [W-1:0] a;
	logic [W-1:0] b;
	logic [W-1:0] sum;
	logic [SHW-1:0] shAmt;
	logic [2*W-1:0] rotL;
	logic [2*W-1:0] rotR;
	logic [W-1:0] bitRev;
	logic ovf;
	logic isLt;
	logic isEq;

	// operand conditioning, sub is ~a + b + 1
	assign a = invA ? ~opA : opA;
	assign b = invB ? ~opB : opB;
	assign sum = a + b + {{(W-1){1'b0}}, cin};

	// signed compare on a - b (b already inverted with carry-in)
	assign ovf = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
	assign isLt = sum[W-1] ^ ovf;
	assign isEq = (sum == '0);

	// rotates via a doubled word
	assign shAmt = opB[SHW-1:0];
	assign rotL = {a, a} << shAmt;
	assign rotR = {a, a} >> shAmt;

	always_comb begin
		for (int i = 0; i < W; i++) begin
			bitRev[i] = a[W-1-i];
		end
	end

	always_comb begin
		case (aluOp)
			ALU_ADD:  result = sum;
			ALU_XOR:  result = a ^ b;
			ALU_ANDN: result = a & b;
			ALU_ROL:  result = rotL[2*W-1:W];
			ALU_SLL:  result = a << shAmt;
			ALU_ROR:  result = rotR[W-1:0];
			ALU_SRL:  result = a >> shAmt;
			ALU_SEQ:  result = {{(W-1){1'b0}}, isEq};
			ALU_SLT:  result = {{(W-1){1'b0}}, isLt};
			ALU_SLE:  result = {{(W-1){1'b0}}, isLt | isEq};
			ALU_BTR:  result = bitRev;
			ALU_LBI:  result = b;
			// byte shifted in at the bottom
			ALU_SLBI: result = (a << 8) | b;
			default:  result = sum;
		endcase
	end

endmodule

//--- rtl/branchUnit.sv
// wisc branch and jump unit
// tests rs against zero for the conditional branches and picks the
// next pc among pc+2, pc-relative and register-relative targets

`timescale 1ns/1ps

`include "wiscCore_settings.svh"

module branchUnit (
	input  wiscPkg::ctrlT ctrl,
	input  wiscPkg::opcodeT opcode,
	input  logic [`WISC_DATA_WIDTH-1:0] rsValue,
	input  logic [`WISC_DATA_WIDTH-1:0] pc,
	input  logic [`WISC_DATA_WIDTH-1:0] imm,
	output logic [`WISC_DATA_WIDTH-1:0] nextPc
);

	import wiscPkg::*;

	logic [`WISC_DATA_WIDTH-1:0] pcInc;
	logic taken;

	assign pcInc = pc + `WISC_DATA_WIDTH'(2);

	// condition on rs only, sign bit for the lt/ge pair
	always_comb begin
		case (opcode)
			OP_BNEZ: taken = (rsValue != '0);
			OP_BEQZ: taken = (rsValue == '0);
			OP_BLTZ: taken = rsValue[`WISC_DATA_WIDTH-1];
			OP_BGEZ: taken = !rsValue[`WISC_DATA_WIDTH-1];
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (ctrl.jump) begin
			// jr / jalr
			nextPc = rsValue + imm;
		end else if (ctrl.pcImm || (ctrl.branching && taken)) begin
			nextPc = pcInc + imm;
		end else begin
			nextPc = pcInc;
		end
	end

endmodule

//--- rtl/dataMem.sv
// wisc data memory
// word-addressed store, combinational read, write on the clock edge

`timescale 1ns/1ps

`include "wiscCore_settings.svh"

module dataMem (
	input  logic clk,
	input  logic reset,
	input  logic [`WISC_DATA_WIDTH-1:0] addr,
	input  logic wrEn,
	input  logic [`WISC_DATA_WIDTH-1:0] wrData,
	output logic [`WISC_DATA_WIDTH-1:0] rdData
);

	localparam int ADDR_BITS = $clog2(`WISC_DMEM_WORDS);

	logic [`WISC_DATA_WIDTH-1:0] mem [`WISC_DMEM_WORDS];
	logic [ADDR_BITS-1:0] wordAddr;

	// byte address in, drop bit 0 and wrap on the depth
	assign wordAddr = addr[ADDR_BITS:1];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `WISC_DMEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (wrEn) begin
			mem[wordAddr] <= wrData;
		end
	end

	assign rdData = mem[wordAddr];

endmodule

//--- rtl/wiscCore.sv
// wisc execute core
// decodes and executes one strobed instruction per cycle and presents
// its retire record on the following cycle

`timescale 1ns/1ps

`include "wiscCore_settings.svh"

module wiscCore (
	input  logic clk,
	input  logic reset,
	input  logic instrValid,
	input  wiscPkg::instrT instr,
	input  logic [`WISC_DATA_WIDTH-1:0] pc,
	output logic retireValid,
	output wiscPkg::retireT retire
);

	import wiscPkg::*;

	localparam int W = `WISC_DATA_WIDTH;
	localparam int RB = $clog2(`WISC_REG_COUNT);

	ctrlT ctrl;
	retireT retireNext;
	logic [W-1:0] rsValue;
	logic [W-1:0] rtValue;
	logic [W-1:0] immExt;
	logic [W-1:0] aluOpB;
	logic [W-1:0] aluResult;
	logic [W-1:0] memRdData;
	logic [W-1:0] branchPc;
	logic [W-1:0] pcInc;
	logic [W-1:0] wbData;
	logic [RB-1:0] wrReg;
	logic regWrEn;
	logic memWrEn;

	control uControl (.opcode(instr.rFmt.opcode), .funct(instr.rFmt.funct), .ctrl(ctrl));

	regFile uRegFile (
		.clk(clk), .reset(reset),
		.rdAddrA(instr.rFmt.rs), .rdAddrB(instr.rFmt.rt),
		.wrEn(regWrEn), .wrAddr(wrReg), .wrData(wbData),
		.rdDataA(rsValue), .rdDataB(rtValue)
	);

	// immediate extension
	always_comb begin
		case (ctrl.seSel)
			SE_ZEXT5:  immExt = {{(W-5){1'b0}}, instr.iFmt1.imm5};
			SE_ZEXT8:  immExt = {{(W-8){1'b0}}, instr.iFmt2.imm8};
			SE_SEXT5:  immExt = {{(W-5){instr.iFmt1.imm5[4]}}, instr.iFmt1.imm5};
			SE_SEXT8:  immExt = {{(W-8){instr.iFmt2.imm8[7]}}, instr.iFmt2.imm8};
			SE_SEXT11: immExt = {{(W-11){instr.jFmt.disp[10]}}, instr.jFmt.disp};
			default:   immExt = '0;
		endcase
	end

	assign aluOpB = ctrl.aluSrc2 ? rtValue : immExt;

	alu uAlu (
		.opA(rsValue), .opB(aluOpB), .aluOp(ctrl.aluOp),
		.invA(ctrl.invA), .invB(ctrl.invB), .cin(ctrl.cin), .result(aluResult)
	);

	branchUnit uBranch (
		.ctrl(ctrl), .opcode(instr.rFmt.opcode), .rsValue(rsValue),
		.pc(pc), .imm(immExt), .nextPc(branchPc)
	);

	// store data is the register in bits 7:5, read on port B
	dataMem uDataMem (
		.clk(clk), .reset(reset), .addr(aluResult),
		.wrEn(memWrEn), .wrData(rtValue), .rdData(memRdData)
	);

	// destination select
	always_comb begin
		case (ctrl.regDst)
			RD_RFMT: wrReg = instr.rFmt.rd;
			RD_IFMT: wrReg = instr.iFmt1.rd;
			RD_RS:   wrReg = instr.rFmt.rs;
			default: wrReg = RB'(`WISC_REG_COUNT - 1);
		endcase
	end

	// writeback: load data, link address for jal/jalr, else alu
	assign pcInc = pc + W'(2);
	assign wbData = ctrl.memToReg ? memRdData :
		(ctrl.regDst == RD_R7) ? pcInc : aluResult;

	// errors never touch architectural state
	assign regWrEn = instrValid && ctrl.regWrite && !ctrl.err;
	assign memWrEn = instrValid && ctrl.memWrite && !ctrl.err;

	always_comb begin
		retireNext.regWrite = ctrl.regWrite && !ctrl.err;
		retireNext.wrReg = wrReg;
		retireNext.wrData = wbData;
		retireNext.nextPc = branchPc;
		retireNext.memWrite = ctrl.memWrite && !ctrl.err;
		retireNext.memAddr = ctrl.memEn ? aluResult : '0;
		retireNext.memData = ctrl.memWrite ? rtValue : '0;
		retireNext.halt = ctrl.halt;
		retireNext.err = ctrl.err;
	end

	//////////////////////////////////////////////////////////////////////
	// retire stage, one record per strobe a cycle later
	always_ff @(posedge clk) begin
		if (reset) begin
			retireValid <= 1'b0;
		end else begin
			retireValid <= instrValid;
		end
	end

	always_ff @(posedge clk) begin
		if (instrValid) begin
			retire <= retireNext;
		end
	end

endmodule

//--- testbench/wiscCoreTb.sv
// wisc execute core testbench
// directed tests that strobe one instruction at a time and compare
// each retire record against a model kept in the testbench

`timescale 1ns/1ps

`include "wiscCore_settings.svh"

module wiscCoreTb;

	import wiscPkg::*;

	localparam int W = `WISC_DATA_WIDTH;
	localparam int RB = $clog2(`WISC_REG_COUNT);
	localparam int CLK_PERIOD = 8;
	localparam int TEST_COUNT = 6;

	logic clk;
	logic reset;
	logic instrValid;
	instrT instr;
	logic [W-1:0] pc;
	logic retireValid;
	retireT retire;

	// model state: register contents and the pc of the next strobe
	logic [W-1:0] shadow [`WISC_REG_COUNT];
	logic [W-1:0] pcNow;
	int seed;

	wiscCore DUT (
		.clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr),
		.pc(pc), .retireValid(retireValid), .retire(retire)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// 200 cycles per test task
	initial begin
		#(TEST_COUNT * 200 * CLK_PERIOD);
		abortRun("watchdog expired before the tests finished");
	end

	//////////////////////////////////////////////////////////////////////
	// reporting and compares
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkWord(input string what, input logic [W-1:0] got,
		input logic [W-1:0] exp);
		if (got !== exp) begin
			abortRun($sformatf("ERR at %0t: %s got %h expected %h",
				$time, what, got, exp));
		end
	endtask

	// wrReg/wrData only count with a register write, memAddr/memData with a store
	task automatic checkRetire(input string what, input retireT got, input retireT exp);
		if (got.regWrite !== exp.regWrite || got.memWrite !== exp.memWrite
			|| got.nextPc !== exp.nextPc || got.halt !== exp.halt || got.err !== exp.err
			|| (exp.regWrite && (got.wrReg !== exp.wrReg || got.wrData !== exp.wrData))
			|| (exp.memWrite
			&& (got.memAddr !== exp.memAddr || got.memData !== exp.memData))) begin
			abortRun($sformatf("ERR at %0t: %s retire %h expected %h",
				$time, what, got, exp));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// encoders and reference model
	function automatic instrT encR(input opcodeT op, input logic [2:0] rs,
		input logic [2:0] rt, input logic [2:0] rd, input functT fn);
		return {op, rs, rt, rd, fn};
	endfunction

	function automatic instrT encI1(input opcodeT op, input logic [2:0] rs,
		input logic [2:0] rd, input logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic instrT encI2(input opcodeT op, input logic [2:0] rs,
		input logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic instrT encJ(input opcodeT op, input logic [10:0] disp);
		return {op, disp};
	endfunction

	function automatic logic [W-1:0] sext5(input logic [4:0] v);
		return {{(W-5){v[4]}}, v};
	endfunction

	function automatic logic [W-1:0] sext8(input logic [7:0] v);
		return {{(W-8){v[7]}}, v};
	endfunction

	function automatic logic [W-1:0] sext11(input logic [10:0] v);
		return {{(W-11){v[10]}}, v};
	endfunction

	function automatic logic [W-1:0] rotl(input logic [W-1:0] v, input logic [3:0] s);
		return (v << s) | (v >> (W - int'(s)));
	endfunction

	function automatic logic [W-1:0] rotr(input logic [W-1:0] v, input logic [3:0] s);
		return (v >> s) | (v << (W - int'(s)));
	endfunction

	function automatic logic [W-1:0] bitRev(input logic [W-1:0] v);
		logic [W-1:0] r;
		for (int i = 0; i < W; i++) begin
			r[i] = v[W-1-i];
		end
		return r;
	endfunction

	function automatic logic [W-1:0] nextSeq();
		return pcNow + 16'd2;
	endfunction

	function automatic retireT makeRetire(input logic wr, input logic [RB-1:0] rd,
		input logic [W-1:0] data, input logic [W-1:0] npc);
		retireT r;
		r = '0;
		r.regWrite = wr;
		r.wrReg = rd;
		r.wrData = data;
		r.nextPc = npc;
		return r;
	endfunction

	// store record, stu also reports the address going back to rs
	function automatic retireT makeStore(input logic wrRs, input logic [2:0] rs,
		input logic [W-1:0] addr, input logic [W-1:0] data);
		retireT r;
		r = makeRetire(wrRs, rs, addr, nextSeq());
		r.memWrite = 1'b1;
		r.memAddr = addr;
		r.memData = data;
		return r;
	endfunction

	function automatic retireT makeFlagged(input logic halt, input logic err);
		retireT r;
		r = makeRetire(1'b0, 3'd0, '0, nextSeq());
		r.halt = halt;
		r.err = err;
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// drivers
	// strobe on the falling edge, retire is sampled one falling edge later
	task automatic execute(input string what, input instrT ins, input retireT exp);
		@(negedge clk);
		instrValid = 1'b1;
		instr = ins;
		pc = pcNow;
		@(posedge clk);
		@(negedge clk);
		instrValid = 1'b0;
		if (retireValid !== 1'b1) begin
			abortRun($sformatf("%s did not retire one cycle after its strobe", what));
		end
		checkRetire(what, retire, exp);
		if (exp.regWrite) begin
			shadow[exp.wrReg] = exp.wrData;
		end
		pcNow = exp.nextPc;
	endtask

	// lbi sign-extends the high byte, slbi shifts it up and merges the low byte
	task automatic loadReg(input logic [2:0] r, input logic [W-1:0] value);
		execute("LBI", encI2(OP_LBI, r, value[W-1:8]),
			makeRetire(1'b1, r, sext8(value[W-1:8]), nextSeq()));
		execute("SLBI", encI2(OP_SLBI, r, value[7:0]),
			makeRetire(1'b1, r, (shadow[r] << 8) | {8'h00, value[7:0]}, nextSeq()));
	endtask

	// addi rs, rs, 0 brings a register out on the retire record
	task automatic readBack(input logic [2:0] r, input logic [W-1:0] value);
		execute("read back", encI1(OP_ADDI, r, r, 5'd0),
			makeRetire(1'b1, r, shadow[r], nextSeq()));
		checkWord($sformatf("r%0d", r), retire.wrData, value);
	endtask

	task automatic branchCase(input string what, input opcodeT op, input logic [2:0] rs,
		input logic [7:0] disp, input logic taken);
		logic [W-1:0] target;
		target = taken ? nextSeq() + sext8(disp) : nextSeq();
		execute(what, encI2(op, rs, disp), makeRetire(1'b0, 3'd0, '0, target));
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	task automatic testArith();
		logic [W-1:0] a;
		logic [W-1:0] b;
		readBack(3'd0, 16'h0000);
		loadReg(3'd1, 16'h1234);
		readBack(3'd1, 16'h1234);
		loadReg(3'd1, 16'hF0A5);
		readBack(3'd1, 16'hF0A5);
		// addi adds, subi takes rs away from the immediate
		execute("ADDI", encI1(OP_ADDI, 3'd1, 3'd2, 5'h1d),
			makeRetire(1'b1, 3'd2, shadow[1] + sext5(5'h1d), nextSeq()));
		execute("SUBI", encI1(OP_SUBI, 3'd1, 3'd3, 5'h07),
			makeRetire(1'b1, 3'd3, sext5(5'h07) - shadow[1], nextSeq()));
		for (int i = 0; i < 4; i++) begin
			a = W'($random(seed));
			b = W'($random(seed));
			loadReg(3'd4, a);
			loadReg(3'd5, b);
			execute("ADD", encR(OP_ALU1, 3'd4, 3'd5, 3'd6, FN_ADD),
				makeRetire(1'b1, 3'd6, a + b, nextSeq()));
			execute("SUB", encR(OP_ALU1, 3'd4, 3'd5, 3'd6, FN_SUB),
				makeRetire(1'b1, 3'd6, b - a, nextSeq()));
			execute("XOR", encR(OP_ALU1, 3'd4, 3'd5, 3'd6, FN_XOR),
				makeRetire(1'b1, 3'd6, a ^ b, nextSeq()));
			execute("ANDN", encR(OP_ALU1, 3'd4, 3'd5, 3'd6, FN_ANDN),
				makeRetire(1'b1, 3'd6, a & ~b, nextSeq()));
		end
	endtask

	task automatic testShifts();
		logic [W-1:0] v;
		logic [3:0] amt;
		logic [4:0] imm;
		for (int i = 0; i < 4; i++) begin
			v = W'($random(seed));
			loadReg(3'd1, v);
			loadReg(3'd2, W'($random(seed)));
			// amount is the low nibble of rt
			amt = shadow[2][3:0];
			execute("ROL", encR(OP_ALU2, 3'd1, 3'd2, 3'd3, FN_ROL),
				makeRetire(1'b1, 3'd3, rotl(v, amt), nextSeq()));
			execute("SLL", encR(OP_ALU2, 3'd1, 3'd2, 3'd3, FN_SLL),
				makeRetire(1'b1, 3'd3, v << amt, nextSeq()));
			execute("ROR", encR(OP_ALU2, 3'd1, 3'd2, 3'd3, FN_ROR),
				makeRetire(1'b1, 3'd3, rotr(v, amt), nextSeq()));
			execute("SRL", encR(OP_ALU2, 3'd1, 3'd2, 3'd3, FN_SRL),
				makeRetire(1'b1, 3'd3, v >> amt, nextSeq()));
			imm = 5'($random(seed));
			execute("ROLI", encI1(OP_ROLI, 3'd1, 3'd4, imm),
				makeRetire(1'b1, 3'd4, rotl(v, imm[3:0]), nextSeq()));
			execute("SRLI", encI1(OP_SRLI, 3'd1, 3'd4, imm),
				makeRetire(1'b1, 3'd4, v >> imm[3:0], nextSeq()));
			execute("BTR", encR(OP_BTR, 3'd1, 3'd0, 3'd5, 2'b00),
				makeRetire(1'b1, 3'd5, bitRev(v), nextSeq()));
			// signed compares, an equal pair and the random pair both ways
			execute("SEQ", encR(OP_SEQ, 3'd1, 3'd1, 3'd6, 2'b00),
				makeRetire(1'b1, 3'd6, 16'd1, nextSeq()));
			execute("SEQ unequal", encR(OP_SEQ, 3'd1, 3'd2, 3'd6, 2'b00),
				makeRetire(1'b1, 3'd6, W'(v == shadow[2]), nextSeq()));
			execute("SLT", encR(OP_SLT, 3'd1, 3'd2, 3'd6, 2'b00),
				makeRetire(1'b1, 3'd6, W'($signed(v) < $signed(shadow[2])), nextSeq()));
			execute("SLE", encR(OP_SLE, 3'd2, 3'd1, 3'd6, 2'b00),
				makeRetire(1'b1, 3'd6, W'($signed(shadow[2]) <= $signed(v)), nextSeq()));
		end
	endtask

	task automatic testMemory();
		loadReg(3'd1, 16'h0010);
		loadReg(3'd2, 16'hBEEF);
		loadReg(3'd5, 16'h000A);
		execute("ST", encI1(OP_ST, 3'd1, 3'd2, 5'h04),
			makeStore(1'b0, 3'd1, 16'h0014, 16'hBEEF));
		execute("LD", encI1(OP_LD, 3'd1, 3'd3, 5'h04),
			makeRetire(1'b1, 3'd3, 16'hBEEF, nextSeq()));
		// negative offset, read back through a different base
		loadReg(3'd4, 16'h5A5A);
		execute("ST back", encI1(OP_ST, 3'd1, 3'd4, 5'h1e),
			makeStore(1'b0, 3'd1, 16'h000E, 16'h5A5A));
		execute("LD other base", encI1(OP_LD, 3'd5, 3'd6, 5'h04),
			makeRetire(1'b1, 3'd6, 16'h5A5A, nextSeq()));
		execute("STU", encI1(OP_STU, 3'd1, 3'd2, 5'h02),
			makeStore(1'b1, 3'd1, 16'h0012, 16'hBEEF));
		readBack(3'd1, 16'h0012);
		execute("LD after STU", encI1(OP_LD, 3'd1, 3'd3, 5'h00),
			makeRetire(1'b1, 3'd3, 16'hBEEF, nextSeq()));
	endtask

	task automatic testControlFlow();
		logic [W-1:0] link;
		loadReg(3'd1, 16'h0000);
		loadReg(3'd2, 16'h0200);
		loadReg(3'd3, 16'h8001);
		branchCase("BEQZ taken", OP_BEQZ, 3'd1, 8'h10, 1'b1);
		branchCase("BEQZ not taken", OP_BEQZ, 3'd2, 8'h10, 1'b0);
		branchCase("BNEZ taken", OP_BNEZ, 3'd2, 8'hF0, 1'b1);
		branchCase("BNEZ not taken", OP_BNEZ, 3'd1, 8'hF0, 1'b0);
		branchCase("BLTZ taken", OP_BLTZ, 3'd3, 8'h08, 1'b1);
		branchCase("BLTZ not taken", OP_BLTZ, 3'd2, 8'h08, 1'b0);
		branchCase("BGEZ taken", OP_BGEZ, 3'd1, 8'h04, 1'b1);
		branchCase("BGEZ not taken", OP_BGEZ, 3'd3, 8'h04, 1'b0);
		execute("J", encJ(OP_J, 11'h7F8),
			makeRetire(1'b0, 3'd0, '0, nextSeq() + sext11(11'h7F8)));
		execute("JR", encI2(OP_JR, 3'd2, 8'h20),
			makeRetire(1'b0, 3'd0, '0, shadow[2] + 16'h0020));
		link = nextSeq();
		execute("JAL", encJ(OP_JAL, 11'h040), makeRetire(1'b1, 3'd7, link, link + 16'h0040));
		readBack(3'd7, link);
		link = nextSeq();
		execute("JALR", encI2(OP_JALR, 3'd2, 8'hFE),
			makeRetire(1'b1, 3'd7, link, shadow[2] + sext8(8'hFE)));
		readBack(3'd7, link);
	endtask

	// fields that would name r6 everywhere, r6 must survive
	task automatic testHaltErr();
		loadReg(3'd6, 16'h1357);
		execute("HALT", encR(OP_HALT, 3'd6, 3'd6, 3'd6, 2'b00), makeFlagged(1'b1, 1'b0));
		execute("SIIC", encR(OP_SIIC, 3'd6, 3'd6, 3'd6, 2'b00), makeFlagged(1'b0, 1'b1));
		execute("RTI", encR(OP_RTI, 3'd6, 3'd6, 3'd6, 2'b00), makeFlagged(1'b0, 1'b1));
		execute("SCO", encR(OP_SCO, 3'd6, 3'd6, 3'd6, 2'b00), makeFlagged(1'b0, 1'b1));
		readBack(3'd6, 16'h1357);
	endtask

	// three strobes in a row, each one depends on the one before
	task automatic testBackToBack();
		instrT prog [3];
		retireT exp [3];
		logic [W-1:0] r2;
		logic [W-1:0] r3;
		loadReg(3'd1, 16'h0003);
		r2 = shadow[1] + 16'h0004;
		r3 = r2 + shadow[1];
		prog[0] = encI1(OP_ADDI, 3'd1, 3'd2, 5'h04);
		prog[1] = encR(OP_ALU1, 3'd2, 3'd1, 3'd3, FN_ADD);
		prog[2] = encR(OP_ALU1, 3'd3, 3'd2, 3'd4, FN_XOR);
		exp[0] = makeRetire(1'b1, 3'd2, r2, pcNow + 16'd2);
		exp[1] = makeRetire(1'b1, 3'd3, r3, pcNow + 16'd4);
		exp[2] = makeRetire(1'b1, 3'd4, r3 ^ r2, pcNow + 16'd6);
		for (int i = 0; i <= 3; i++) begin
			@(negedge clk);
			if (i > 0) begin
				if (retireValid !== 1'b1) begin
					abortRun($sformatf("burst instruction %0d did not retire", i - 1));
				end
				checkRetire($sformatf("burst %0d", i - 1), retire, exp[i-1]);
				shadow[exp[i-1].wrReg] = exp[i-1].wrData;
			end
			if (i < 3) begin
				instrValid = 1'b1;
				instr = prog[i];
				pc = pcNow;
				pcNow = pcNow + 16'd2;
			end else begin
				instrValid = 1'b0;
			end
		end
		@(negedge clk);
		if (retireValid !== 1'b0) begin
			abortRun("retireValid stayed high after the last strobe of the burst");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	initial begin
		seed = 32'he20b218b;
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		pcNow = 16'h0100;
		for (int i = 0; i < `WISC_REG_COUNT; i++) begin
			shadow[i] = '0;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		if (retireValid !== 1'b0) begin
			abortRun("retireValid is high right after reset");
		end
		testArith();
		testShifts();
		testMemory();
		testControlFlow();
		testHaltErr();
		testBackToBack();
		$display("Test passed");
		$finish;
	end

endmodule

//--- flist.f
+incdir+rtl
rtl/wiscPkg.sv
rtl/control.sv
rtl/regFile.sv
rtl/alu.sv
rtl/branchUnit.sv
rtl/dataMem.sv
rtl/wiscCore.sv
testbench/wiscCoreTb.sv

//--- Makefile
# Verilator build and run of the wisc core testbench

BIN := obj_dir/VwiscCoreTb
SRCS := flist.f $(wildcard rtl/*.sv rtl/*.svh testbench/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps --top-module wiscCoreTb -f flist.f

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir
